// ==== filelist.f ====
common/mipsPkg.sv
hdl/memStage.sv
hdl/dataRam.sv
hdl/writebackStage.sv
hdl/regFile.sv
hdl/memWbTop.sv
tests/memWbTb.sv

// ==== run.sh ====
#!/bin/bash
# Builds the memory/write-back testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module memWbTb -o memWbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memWbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== tests/memWbTb.sv ====
`default_nettype none

module memWbTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    localparam int waitLimit = 20; // Cycles before a wait gives up.

    logic clk;
    logic rstN;
    logic exValid;
    exResultT exIn;
    regAddrT rdAddr;
    wordT rdData;
    hiLoT hiLo;
    excT excOut;
    wordT pcOut;
    logic isDsOut;
    logic retireValid;

    int errors;
    int timeouts;
    logic [31:0] lfsrState;

    memWbTop i_dut (
        .clk(clk),
        .rstN(rstN),
        .exValid(exValid),
        .exIn(exIn),
        .rdAddr(rdAddr),
        .rdData(rdData),
        .hiLo(hiLo),
        .excOut(excOut),
        .pcOut(pcOut),
        .isDsOut(isDsOut),
        .retireValid(retireValid)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic lfsrStep();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic wordT randomWord();
        wordT value;
        value = '0;
        for (int i = 0; i < 32; i++)
            value = {value[30:0], lfsrStep()};
        return value;
    endfunction

    function automatic exResultT blankItem(wordT pc);
        exResultT item;
        item = '0;
        item.pc = pc;
        item.epc = pc;
        item.isDs = pc[2]; // Delay-slot flag alternates with the PC.
        return item;
    endfunction

    function automatic exResultT loadItem(wordT addr, memSizeT size, logic signExt, regAddrT rd,
                                          wordT pc);
        exResultT item;
        item = blankItem(pc);
        item.aluOut = addr;
        item.mem.rd = 1'b1;
        item.mem.size = size;
        item.mem.signExt = signExt;
        item.regWrite = 1'b1;
        item.rd = rd;
        return item;
    endfunction

    function automatic exResultT storeItem(wordT addr, wordT data, memSizeT size, wordT pc);
        exResultT item;
        item = blankItem(pc);
        item.aluOut = addr;
        item.storeData = data;
        item.mem.wr = 1'b1;
        item.mem.size = size;
        return item;
    endfunction

    function automatic exResultT aluItem(wordT value, regAddrT rd, wordT pc);
        exResultT item;
        item = blankItem(pc);
        item.aluOut = value;
        item.regWrite = 1'b1;
        item.rd = rd;
        return item;
    endfunction

    // Lane pick by shifting, extension by a signed cast.
    function automatic wordT expectLoad(wordT word, logic [1:0] offset, memSizeT size,
                                        logic signExt);
        wordT shifted;
        shifted = word >> (8 * offset);
        if (size == sizeByte)
            return signExt ? wordT'($signed(shifted[7:0])) : wordT'(shifted[7:0]);
        else if (size == sizeHalf)
            return signExt ? wordT'($signed(shifted[15:0])) : wordT'(shifted[15:0]);
        return word;
    endfunction

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s: expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkHiLo(input string name, input hiLoT expected, input hiLoT actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s: expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkExc(input string name, input excT expected, input excT actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s: expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s: expected %b, got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Holds the item on exIn for one cycle.
    task automatic issueItem(input exResultT item);
        @(negedge clk);
        exValid = 1'b1;
        exIn = item;
        @(negedge clk);
        exValid = 1'b0;
    endtask

    // Returns once the item has retired.
    task automatic runItem(input exResultT item, input excT expExc);
        int cycles;
        issueItem(item);
        cycles = 0;
        while (!retireValid && cycles < waitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!retireValid)
        begin
            $display("Timeout at %0t: item with pc %h never retired", $time, item.pc);
            timeouts++;
        end
        checkExc("excOut", expExc, excOut);
        checkWord("pcOut", item.pc, pcOut);
        checkFlag("isDsOut", item.isDs, isDsOut);
    endtask

    task automatic checkReg(input regAddrT addr, input wordT expected, input string name);
        @(negedge clk);
        rdAddr = addr;
        #1;
        checkWord(name, expected, rdData);
    endtask

    task automatic testWordStoreLoad();
        wordT addr;
        wordT data;
        addr = randomWord() & 32'h0000_0ffc;
        data = randomWord();
        runItem(storeItem(addr, data, sizeWord, 32'h400), excNone);
        runItem(loadItem(addr, sizeWord, 1'b0, 5'd5, 32'h404), excNone);
        checkReg(5'd5, data, "rdData word load");
    endtask

    task automatic testSubwordLoads();
        wordT word;
        wordT pc;
        word = 32'h7a13_c381; // Lanes with and without the sign bit.
        pc = 32'h500;
        runItem(storeItem(32'h100, word, sizeWord, pc), excNone);
        for (int s = 0; s < 2; s++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                pc += 4;
                runItem(loadItem(32'h100 + off, sizeByte, s[0], 5'd6, pc), excNone);
                checkReg(5'd6, expectLoad(word, off[1:0], sizeByte, s[0]),
                         $sformatf("rdData byte offset %0d signExt %0d", off, s));
            end
            for (int off = 0; off < 4; off += 2)
            begin
                pc += 4;
                runItem(loadItem(32'h100 + off, sizeHalf, s[0], 5'd6, pc), excNone);
                checkReg(5'd6, expectLoad(word, off[1:0], sizeHalf, s[0]),
                         $sformatf("rdData half offset %0d signExt %0d", off, s));
            end
        end
    endtask

    task automatic testSubwordStores();
        wordT data;
        wordT expected;
        expected = 32'h1122_3344;
        runItem(storeItem(32'h200, expected, sizeWord, 32'h600), excNone);
        data = randomWord(); // Upper bytes must not leak into memory.
        expected[23:16] = data[7:0];
        runItem(storeItem(32'h202, data, sizeByte, 32'h604), excNone);
        runItem(loadItem(32'h200, sizeWord, 1'b0, 5'd7, 32'h608), excNone);
        checkReg(5'd7, expected, "rdData after byte store");
        data = randomWord();
        expected[15:0] = data[15:0];
        runItem(storeItem(32'h200, data, sizeHalf, 32'h60c), excNone);
        runItem(loadItem(32'h200, sizeWord, 1'b0, 5'd7, 32'h610), excNone);
        checkReg(5'd7, expected, "rdData after half store");
    endtask

    task automatic testMisalign();
        wordT oldReg;
        oldReg = 32'h5555_aaaa;
        runItem(aluItem(oldReg, 5'd8, 32'h700), excNone);
        runItem(storeItem(32'h300, 32'hcafe_f00d, sizeWord, 32'h704), excNone);
        runItem(loadItem(32'h301, sizeHalf, 1'b1, 5'd8, 32'h708), excLoadAddr);
        checkReg(5'd8, oldReg, "rdData after misaligned load");
        runItem(storeItem(32'h302, randomWord(), sizeWord, 32'h70c), excStoreAddr);
        runItem(loadItem(32'h300, sizeWord, 1'b0, 5'd9, 32'h710), excNone);
        checkReg(5'd9, 32'hcafe_f00d, "rdData after misaligned store");
    endtask

    task automatic testExcGating();
        exResultT item;
        hiLoT kept;
        item = aluItem(32'h1357_9bdf, 5'd10, 32'h800);
        item.exc = excDeferred;
        item.epc = 32'h900;
        item.hiLoWrite = 1'b1;
        item.hiLo = {randomWord(), randomWord()};
        kept = item.hiLo;
        runItem(item, excDeferred);
        checkReg(5'd10, 32'h1357_9bdf, "rdData deferred with aligned epc");
        checkHiLo("hiLo deferred with aligned epc", kept, hiLo);
        item = aluItem(32'h2468_ace0, 5'd11, 32'h804);
        item.exc = excDeferred;
        item.epc = 32'h902; // Misaligned EPC blocks the write.
        item.hiLoWrite = 1'b1;
        item.hiLo = {randomWord(), randomWord()};
        runItem(item, excDeferred);
        checkReg(5'd11, 32'h0, "rdData deferred with misaligned epc");
        checkHiLo("hiLo deferred with misaligned epc", kept, hiLo);
        item = aluItem(32'h0bad_0bad, 5'd12, 32'h808);
        item.exc = 4'd9;
        item.hiLoWrite = 1'b1;
        item.hiLo = {randomWord(), randomWord()};
        runItem(item, 4'd9);
        checkReg(5'd12, 32'h0, "rdData other exception");
        checkHiLo("hiLo other exception", kept, hiLo);
    endtask

    task automatic testBackToBack();
        exResultT items [4];
        regAddrT dests [4];
        wordT values [4];
        int retired;
        int cycles;
        dests = '{5'd13, 5'd14, 5'd0, 5'd15};
        for (int k = 0; k < 4; k++)
        begin
            values[k] = randomWord();
            items[k] = aluItem(values[k], dests[k], 32'ha00 + 4 * k);
        end
        retired = 0;
        cycles = 0;
        @(negedge clk);
        while (retired < 4 && cycles < waitLimit)
        begin
            if (retireValid)
            begin
                checkWord("pcOut back-to-back", items[retired].pc, pcOut);
                checkFlag("isDsOut back-to-back", items[retired].isDs, isDsOut);
                retired++;
            end
            exValid = (cycles < 4);
            if (cycles < 4)
                exIn = items[cycles];
            @(negedge clk);
            cycles++;
        end
        exValid = 1'b0;
        if (retired != 4)
        begin
            $display("Timeout at %0t: only %0d of 4 back-to-back items retired", $time, retired);
            timeouts++;
        end
        checkReg(5'd13, values[0], "rdData r13");
        checkReg(5'd14, values[1], "rdData r14");
        checkReg(5'd15, values[3], "rdData r15");
        checkReg(5'd0, 32'h0, "rdData r0");
    endtask

    initial
    begin
        errors = 0;
        timeouts = 0;
        lfsrState = 32'h9c90_b43f;
        rstN = 1'b0;
        exValid = 1'b0;
        exIn = '0;
        rdAddr = '0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        testWordStoreLoad();
        testSubwordLoads();
        testSubwordStores();
        testMisalign();
        testExcGating();
        testBackToBack();
        $display("Checks finished with %0d mismatches and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/memWbTop.sv ====
`default_nettype none

module memWbTop (
    input logic clk,
    input logic rstN,
    input logic exValid,
    input mipsPkg::exResultT exIn,
    input mipsPkg::regAddrT rdAddr,
    output mipsPkg::wordT rdData,
    output mipsPkg::hiLoT hiLo,
    output mipsPkg::excT excOut,
    output mipsPkg::wordT pcOut,
    output logic isDsOut,
    output logic retireValid
);
    import mipsPkg::*;

    wordT ramAddr;
    logic [3:0] ramWe;
    wordT ramWData;
    wordT ramRData;
    logic memValid;
    memResultT memResult;
    wbWriteT wbWrite;

    memStage i_memStage (
        .clk(clk),
        .rstN(rstN),
        .exValid(exValid),
        .exIn(exIn),
        .ramAddr(ramAddr),
        .ramWe(ramWe),
        .ramWData(ramWData),
        .memValid(memValid),
        .memResult(memResult)
    );

    dataRam i_dataRam (
        .clk(clk),
        .ramAddr(ramAddr),
        .ramWe(ramWe),
        .ramWData(ramWData),
        .ramRData(ramRData)
    );

    writebackStage i_writebackStage (
        .clk(clk),
        .rstN(rstN),
        .memValid(memValid),
        .memResult(memResult),
        .ramRData(ramRData),
        .wbWrite(wbWrite),
        .retireValid(retireValid),
        .excOut(excOut),
        .pcOut(pcOut),
        .isDsOut(isDsOut)
    );

    regFile i_regFile (
        .clk(clk),
        .rstN(rstN),
        .wbWrite(wbWrite),
        .rdAddr(rdAddr),
        .rdData(rdData),
        .hiLo(hiLo)
    );

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`default_nettype none

module regFile (
    input logic clk,
    input logic rstN,
    input mipsPkg::wbWriteT wbWrite,
    input mipsPkg::regAddrT rdAddr,
    output mipsPkg::wordT rdData,
    output mipsPkg::hiLoT hiLo
);
    import mipsPkg::*;

    wordT regs [regCount];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end
        else if (wbWrite.regWrite && wbWrite.rd != '0)
        begin
            regs[wbWrite.rd] <= wbWrite.data;
        end
    end

    // HI and LO always move as a pair.
    always_ff @(posedge clk)
    begin
        if (!rstN)
            hiLo <= '0;
        else if (wbWrite.hiLoWrite)
            hiLo <= wbWrite.hiLo;
    end

    assign rdData = (rdAddr == '0) ? '0 : regs[rdAddr]; // No write bypass.

endmodule

`default_nettype wire

// ==== hdl/writebackStage.sv ====
`default_nettype none

module writebackStage (
    input logic clk,
    input logic rstN,
    input logic memValid,
    input mipsPkg::memResultT memResult,
    input mipsPkg::wordT ramRData,
    output mipsPkg::wbWriteT wbWrite,
    output logic retireValid,
    output mipsPkg::excT excOut,
    output mipsPkg::wordT pcOut,
    output logic isDsOut
);
    import mipsPkg::*;

    memResultT wbReg;
    logic [1:0] offset;
    logic [7:0] byteSel;
    logic [15:0] halfSel;
    wordT loadData;
    logic writeAllowed;
    logic loadMisaligned;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            retireValid <= 1'b0;
        else
            retireValid <= memValid;
    end

    always_ff @(posedge clk)
    begin
        if (memValid)
            wbReg <= memResult;
    end

    assign offset = wbReg.aluOut[1:0];
    assign byteSel = ramRData[{offset, 3'b000} +: 8];
    assign halfSel = offset[1] ? ramRData[31:16] : ramRData[15:0];

    always_comb
    begin
        case (wbReg.mem.size)
            sizeByte: loadData = {{24{wbReg.mem.signExt & byteSel[7]}}, byteSel};
            sizeHalf: loadData = {{16{wbReg.mem.signExt & halfSel[15]}}, halfSel};
            default: loadData = ramRData;
        endcase
    end

    // A deferred exception still retires when its EPC is word aligned.
    assign writeAllowed = retireValid
        && (wbReg.exc == excNone
            || (wbReg.exc == excDeferred && wbReg.epc[1:0] == 2'b00));

    always_comb
    begin
        wbWrite.regWrite = writeAllowed && wbReg.regWrite && wbReg.rd != '0;
        wbWrite.rd = wbReg.rd;
        wbWrite.data = wbReg.mem.rd ? loadData : wbReg.aluOut;
        wbWrite.hiLoWrite = writeAllowed && wbReg.hiLoWrite;
        wbWrite.hiLo = wbReg.hiLo;
    end

    assign excOut = wbReg.exc;
    assign pcOut = wbReg.pc;
    assign isDsOut = wbReg.isDs;

    assign loadMisaligned = (wbReg.mem.size == sizeHalf && offset[0])
        || (wbReg.mem.size == sizeWord && offset != 2'b00);

    // The memory stage must have flagged this load.
    assert property (@(posedge clk) disable iff (!rstN)
        retireValid && wbReg.mem.rd && loadMisaligned |-> wbReg.exc != excNone);

endmodule

`default_nettype wire

// ==== hdl/dataRam.sv ====
`default_nettype none

module dataRam (
    input logic clk,
    input mipsPkg::wordT ramAddr,
    input logic [3:0] ramWe,
    input mipsPkg::wordT ramWData,
    output mipsPkg::wordT ramRData
);
    import mipsPkg::*;

    wordT mem [2**ramDepthLog];
    logic [ramDepthLog-1:0] wordAddr;
    wordT mergedWord;

    assign wordAddr = ramAddr[ramDepthLog+1:2]; // Drop the byte offset.

    // Read data already shows this cycle's store.
    always_comb
    begin
        mergedWord = mem[wordAddr];
        for (int lane = 0; lane < laneCount; lane++)
        begin
            if (ramWe[lane])
                mergedWord[lane*8 +: 8] = ramWData[lane*8 +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        for (int lane = 0; lane < laneCount; lane++)
        begin
            if (ramWe[lane])
                mem[wordAddr][lane*8 +: 8] <= ramWData[lane*8 +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        ramRData <= mergedWord;
    end

endmodule

`default_nettype wire

// ==== hdl/memStage.sv ====
`default_nettype none

module memStage (
    input logic clk,
    input logic rstN,
    input logic exValid,
    input mipsPkg::exResultT exIn,
    output mipsPkg::wordT ramAddr,
    output logic [3:0] ramWe,
    output mipsPkg::wordT ramWData,
    output logic memValid,
    output mipsPkg::memResultT memResult
);
    import mipsPkg::*;

    exResultT exReg;
    logic misaligned;
    excT excNext;
    logic [3:0] byteEn;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            memValid <= 1'b0;
        else
            memValid <= exValid;
    end

    always_ff @(posedge clk)
    begin
        if (exValid)
            exReg <= exIn;
    end

    always_comb
    begin
        case (exReg.mem.size)
            sizeHalf: misaligned = exReg.aluOut[0];
            sizeWord: misaligned = |exReg.aluOut[1:0];
            default: misaligned = 1'b0; // Bytes are always aligned.
        endcase
    end

    // An earlier exception takes priority over the alignment check.
    always_comb
    begin
        excNext = exReg.exc;
        if (exReg.exc == excNone && misaligned)
        begin
            if (exReg.mem.rd)
                excNext = excLoadAddr;
            else if (exReg.mem.wr)
                excNext = excStoreAddr;
        end
    end

    // Replicate sub-word store data into every lane it may land in.
    always_comb
    begin
        ramWData = exReg.storeData;
        case (exReg.mem.size)
            sizeByte:
            begin
                ramWData = {4{exReg.storeData[7:0]}};
                byteEn = 4'b0001 << exReg.aluOut[1:0];
            end
            sizeHalf:
            begin
                ramWData = {2{exReg.storeData[15:0]}};
                byteEn = exReg.aluOut[1] ? 4'b1100 : 4'b0011;
            end
            default: byteEn = 4'b1111;
        endcase
    end

    assign ramAddr = exReg.aluOut;
    assign ramWe = (memValid && exReg.mem.wr && excNext == excNone) ? byteEn : 4'b0000;

    always_comb
    begin
        memResult.aluOut = exReg.aluOut;
        memResult.mem = exReg.mem;
        memResult.regWrite = exReg.regWrite;
        memResult.rd = exReg.rd;
        memResult.hiLoWrite = exReg.hiLoWrite;
        memResult.hiLo = exReg.hiLo;
        memResult.pc = exReg.pc;
        memResult.epc = exReg.epc;
        memResult.exc = excNext;
        memResult.isDs = exReg.isDs;
    end

    // Execute never issues a load and a store as one item.
    assert property (@(posedge clk) disable iff (!rstN)
        exValid |-> !(exIn.mem.rd && exIn.mem.wr));

endmodule

`default_nettype wire

// ==== common/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    localparam int ramDepthLog = 10; // Word-address bits of the data RAM.
    localparam int regCount = 32;
    localparam int laneCount = 4; // Byte lanes per word.

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;
    typedef logic [63:0] hiLoT; // HI in [63:32], LO in [31:0].
    typedef logic [3:0] excT;

    localparam excT excNone = 4'd0;
    localparam excT excLoadAddr = 4'd4; // Misaligned load.
    localparam excT excStoreAddr = 4'd5; // Misaligned store.
    localparam excT excDeferred = 4'd6; // Retires its own write if the EPC is aligned.

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSizeT;

    typedef struct packed {
        logic rd;
        logic wr;
        memSizeT size;
        logic signExt; // Sign-extend sub-word loads.
    } memReqT;

    // Result of the execute stage, one per valid strobe.
    typedef struct packed {
        wordT aluOut; // Effective address for memory operations.
        wordT storeData;
        memReqT mem;
        logic regWrite;
        regAddrT rd;
        logic hiLoWrite;
        hiLoT hiLo;
        wordT pc;
        wordT epc;
        excT exc;
        logic isDs; // Instruction sits in a delay slot.
    } exResultT;

    typedef struct packed {
        wordT aluOut;
        memReqT mem;
        logic regWrite;
        regAddrT rd;
        logic hiLoWrite;
        hiLoT hiLo;
        wordT pc;
        wordT epc;
        excT exc; // Includes the alignment check.
        logic isDs;
    } memResultT;

    typedef struct packed {
        logic regWrite;
        regAddrT rd;
        wordT data;
        logic hiLoWrite;
        hiLoT hiLo;
    } wbWriteT;

endpackage

`default_nettype wire
